// ==== sources.f ====
common/cache_pkg.sv
logic/axi_burst_master.sv
cache/cache_way.sv
cache/way_merge.sv
cache/cache_ctrl.sv
cache/cache_top.sv
verif/axi_mem_model.sv
verif/tb_cache.sv

// ==== Makefile ====
# Verilator build and run for the cache testbench

VERILATOR ?= verilator
TOP       ?= tb_cache
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= sources.f
VFLAGS    ?= --binary --assert --timescale 1ns/1ps

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q -F '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verif/tb_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cache;
    import cache_pkg::*;

    localparam int mem_words = 16384;
    // about 60 requests at under 300 cycles each
    localparam int max_cycles = 20000;
    localparam int rand_reqs  = 45;
    localparam int lat_any    = 0;
    localparam int lat_hit    = 1;
    localparam int lat_miss   = 2;

    logic       clk = 1'b0;
    logic       arst_n;
    logic       req_valid;
    cache_req_t req;
    logic       rsp_valid;
    cache_rsp_t rsp;
    logic       ar_valid;
    axi_addr_t  ar;
    logic       ar_ready;
    logic       r_valid;
    axi_data_t  r;
    logic       r_ready;
    logic       aw_valid;
    axi_addr_t  aw;
    logic       aw_ready;
    logic       w_valid;
    axi_data_t  w;
    logic       w_ready;
    logic       b_valid;

    logic [WORD_W-1:0] ref_mem [mem_words];
    logic [WORD_W-1:0] exp_data;
    logic              exp_read;
    int                lat_kind;
    logic              pending;
    int                requests = 0;
    int                assert_errors = 0;
    int                mem_errors = 0;
    int                cycles = 0;
    integer            seed = 32'h7621;
    logic [31:0]       rnd;
    logic [31:0]       rnd_data;

    cache_top u_dut (.*);

    axi_mem_model #(.mem_words(mem_words)) u_mem (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            $display("run timed out after %0d cycles", cycles);
            $display("requests %0d, assertion errors %0d, memory errors %0d",
                     requests, assert_errors, mem_errors);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // outputs are sampled mid-cycle, away from the rising edge
    reset_state_chk: assert property (@(negedge clk)
        !arst_n |-> !rsp_valid && !ar_valid && !aw_valid && !w_valid)
    else begin
        assert_errors++;
        $display("an output valid was high during reset");
    end

    read_data_chk: assert property (@(negedge clk) disable iff (!arst_n)
        rsp_valid && exp_read |-> rsp.rdata == exp_data)
    else begin
        assert_errors++;
        $display("ERR rsp.rdata addr %h expected %h got %h", req.addr, exp_data, rsp.rdata);
    end

    hit_latency_chk: assert property (@(negedge clk) disable iff (!arst_n)
        req_valid && lat_kind == lat_hit |-> rsp_valid)
    else begin
        assert_errors++;
        $display("request at %h should hit but got no response in the next cycle", req.addr);
    end

    miss_latency_chk: assert property (@(negedge clk) disable iff (!arst_n)
        req_valid && lat_kind == lat_miss |-> !rsp_valid)
    else begin
        assert_errors++;
        $display("request at %h should miss but responded in the next cycle", req.addr);
    end

    single_rsp_chk: assert property (@(negedge clk) disable iff (!arst_n)
        rsp_valid |-> pending)
    else begin
        assert_errors++;
        $display("response strobe with no request outstanding");
    end

    function automatic logic [WORD_W-1:0] word_pattern(input logic [ADDR_W-1:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
    endfunction

    // one request, then wait for its response
    task automatic access(input logic [ADDR_W-1:0] addr, input logic wr,
                          input logic [STRB_W-1:0] be, input logic [WORD_W-1:0] wdata,
                          input int lat);
        int idx;
        idx = int'(addr >> 2);
        @(negedge clk);
        req_valid = 1'b1;
        req.addr  = addr;
        req.write = wr;
        req.strb  = be;
        req.wdata = wdata;
        exp_read  = !wr;
        exp_data  = ref_mem[idx];
        lat_kind  = lat;
        pending   = 1'b1;
        requests++;
        for (int b = 0; b < STRB_W; b++) begin
            if (wr && be[b]) begin
                ref_mem[idx][8*b +: 8] = wdata[8*b +: 8];
            end
        end
        @(negedge clk);
        req_valid = 1'b0;
        while (!rsp_valid) begin
            @(negedge clk);
        end
        pending = 1'b0;
    endtask

    task automatic compare_line(input logic [ADDR_W-1:0] line_addr);
        int base;
        base = int'(line_addr >> 2);
        for (int i = 0; i < WORDS_PER_LINE; i++) begin
            assert (u_mem.mem[base + i] == ref_mem[base + i])
            else begin
                mem_errors++;
                $display("ERR u_mem.mem[%h] expected %h got %h",
                         base + i, ref_mem[base + i], u_mem.mem[base + i]);
            end
        end
    endtask

    initial begin
        arst_n    = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        exp_read  = 1'b0;
        exp_data  = '0;
        lat_kind  = lat_any;
        pending   = 1'b0;
        for (int i = 0; i < mem_words; i++) begin
            ref_mem[i] = word_pattern(32'(i * 4));
        end
        repeat (4) @(negedge clk);
        arst_n = 1'b1;

        // cold read, then the same word again
        access(32'h0000_0104, 1'b0, '0, '0, lat_miss);
        access(32'h0000_0104, 1'b0, '0, '0, lat_hit);

        // partial write hit and read back
        access(32'h0000_0108, 1'b1, 4'b0101, 32'hdead_beef, lat_hit);
        access(32'h0000_0108, 1'b0, '0, '0, lat_hit);

        // three lines in set 20, the first one dirty
        access(32'h0000_028c, 1'b1, 4'b1111, 32'h1234_5678, lat_miss);
        access(32'h0000_1280, 1'b0, '0, '0, lat_miss);
        access(32'h0000_2280, 1'b0, '0, '0, lat_miss);
        compare_line(32'h0000_0280);
        access(32'h0000_028c, 1'b0, '0, '0, lat_miss);

        // lru order in set 40: A, B, A, C evicts B
        access(32'h0000_0500, 1'b0, '0, '0, lat_miss);
        access(32'h0000_1500, 1'b0, '0, '0, lat_miss);
        access(32'h0000_0500, 1'b0, '0, '0, lat_hit);
        access(32'h0000_2500, 1'b0, '0, '0, lat_miss);
        access(32'h0000_0500, 1'b0, '0, '0, lat_hit);
        access(32'h0000_1500, 1'b0, '0, '0, lat_miss);

        // four tags over sets 3 and 4
        for (int n = 0; n < rand_reqs; n++) begin
            rnd      = $random(seed);
            rnd_data = $random(seed);
            access({16'h0, 2'b00, rnd[1:0], (rnd[2] ? 7'd4 : 7'd3), rnd[5:3], 2'b00},
                   rnd[6], rnd[10:7], rnd_data, lat_any);
        end

        repeat (2) @(negedge clk);
        $display("requests %0d, assertion errors %0d, memory errors %0d",
                 requests, assert_errors, mem_errors);
        if (assert_errors == 0 && mem_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/axi_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model #(
    parameter int mem_words = 16384
) (
    input  wire                        clk,
    input  wire                        arst_n,
    input  wire                        ar_valid,
    input  wire cache_pkg::axi_addr_t  ar,
    output logic                       ar_ready,
    output logic                       r_valid,
    output cache_pkg::axi_data_t       r,
    input  wire                        r_ready,
    input  wire                        aw_valid,
    input  wire cache_pkg::axi_addr_t  aw,
    output logic                       aw_ready,
    input  wire                        w_valid,
    input  wire cache_pkg::axi_data_t  w,
    output logic                       w_ready,
    output logic                       b_valid
);
    import cache_pkg::*;

    localparam int idx_w  = $clog2(mem_words);
    localparam int line_w = idx_w - WORD_SEL_W;

    logic [WORD_W-1:0]     mem [mem_words];
    integer                seed = 32'h7621;
    logic                  rd_busy;
    logic [line_w-1:0]     rd_line;
    logic [WORD_SEL_W-1:0] rd_cnt;
    logic                  wr_busy;
    logic [line_w-1:0]     wr_line;
    logic [WORD_SEL_W-1:0] wr_cnt;
    logic                  b_pend;

    function automatic logic [WORD_W-1:0] word_pattern(input logic [ADDR_W-1:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
    endfunction

    initial begin
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = word_pattern(32'(i * 4));
        end
        ar_ready = 1'b0;
        r_valid  = 1'b0;
        r        = '0;
        aw_ready = 1'b0;
        w_ready  = 1'b0;
        b_valid  = 1'b0;
    end

    // handshakes seen at the rising edge
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_busy <= 1'b0;
            rd_line <= '0;
            rd_cnt  <= '0;
            wr_busy <= 1'b0;
            wr_line <= '0;
            wr_cnt  <= '0;
            b_pend  <= 1'b0;
        end else begin
            if (ar_valid && ar_ready) begin
                rd_busy <= 1'b1;
                rd_line <= ar.addr[idx_w+1:OFFSET_W];
                rd_cnt  <= '0;
            end
            if (r_valid && r_ready) begin
                rd_cnt <= rd_cnt + 1'b1;
                if (r.last) begin
                    rd_busy <= 1'b0;
                end
            end
            if (aw_valid && aw_ready) begin
                wr_busy <= 1'b1;
                wr_line <= aw.addr[idx_w+1:OFFSET_W];
                wr_cnt  <= '0;
            end
            if (w_valid && w_ready) begin
                mem[{wr_line, wr_cnt}] <= w.data;
                wr_cnt <= wr_cnt + 1'b1;
                if (w.last) begin
                    wr_busy <= 1'b0;
                    b_pend  <= 1'b1;
                end
            end
            // b is a single-cycle pulse
            if (b_valid) begin
                b_pend <= 1'b0;
            end
        end
    end

    // ready drops about one cycle in four
    always @(negedge clk) begin
        ar_ready <= !rd_busy && (($random(seed) & 3) != 0);
        aw_ready <= !wr_busy && (($random(seed) & 3) != 0);
        w_ready  <= wr_busy && (($random(seed) & 3) != 0);
        r_valid  <= rd_busy;
        r.data   <= mem[{rd_line, rd_cnt}];
        r.last   <= (rd_cnt == 3'(BURST_LEN));
        b_valid  <= b_pend;
    end

endmodule

`default_nettype wire

// ==== cache/cache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_top #(
    parameter int index_w = cache_pkg::DEF_INDEX_W
) (
    input  wire                    clk,
    input  wire                    arst_n,
    input  wire                    req_valid,
    input  wire cache_pkg::cache_req_t  req,
    output wire                    rsp_valid,
    output wire cache_pkg::cache_rsp_t  rsp,
    output wire                    ar_valid,
    output wire cache_pkg::axi_addr_t   ar,
    input  wire                    ar_ready,
    input  wire                    r_valid,
    input  wire cache_pkg::axi_data_t   r,
    output wire                    r_ready,
    output wire                    aw_valid,
    output wire cache_pkg::axi_addr_t   aw,
    input  wire                    aw_ready,
    output wire                    w_valid,
    output wire cache_pkg::axi_data_t   w,
    input  wire                    w_ready,
    input  wire                    b_valid
);
    import cache_pkg::*;

    localparam int tag_w = ADDR_W - index_w - OFFSET_W;

    wire [index_w-1:0]          lookup_index;
    wire way_wr_t               way_wr;
    wire [WAYS-1:0]             way_we;
    wire [WAYS-1:0][tag_w-1:0]  way_tag;
    wire [WAYS-1:0]             way_valid;
    wire [WAYS-1:0]             way_dirty;
    wire line_t [WAYS-1:0]      way_line;
    wire                        hit;
    wire                        hit_way;
    wire [WORD_W-1:0]           hit_word;
    wire                        victim_dirty;
    wire                        victim_way;
    wire line_t                 victim_line;
    wire [ADDR_W-1:0]           victim_addr;
    wire [tag_w-1:0]            req_tag;
    wire [WORD_SEL_W-1:0]       req_word;
    wire                        fill_start;
    wire                        fill_dirty;
    wire                        fill_beat;
    wire [WORD_W-1:0]           fill_data;
    wire                        fill_done;

    cache_ctrl #(.index_w(index_w)) u_ctrl (
        .clk          (clk),
        .arst_n       (arst_n),
        .req_valid    (req_valid),
        .req          (req),
        .rsp_valid    (rsp_valid),
        .rsp          (rsp),
        .lookup_index (lookup_index),
        .way_wr       (way_wr),
        .way_we       (way_we),
        .hit          (hit),
        .hit_way      (hit_way),
        .hit_word     (hit_word),
        .victim_dirty (victim_dirty),
        .req_tag      (req_tag),
        .req_word     (req_word),
        .victim_way   (victim_way),
        .fill_start   (fill_start),
        .fill_dirty   (fill_dirty),
        .fill_beat    (fill_beat),
        .fill_data    (fill_data),
        .fill_done    (fill_done)
    );

    for (genvar g = 0; g < WAYS; g++) begin : g_way
        cache_way #(.index_w(index_w)) u_way (
            .clk          (clk),
            .arst_n       (arst_n),
            .lookup_index (lookup_index),
            .wr           (way_wr),
            .we           (way_we[g]),
            .tag          (way_tag[g]),
            .valid        (way_valid[g]),
            .dirty        (way_dirty[g]),
            .line         (way_line[g])
        );
    end

    way_merge #(.index_w(index_w)) u_merge (
        .way_tag      (way_tag),
        .way_valid    (way_valid),
        .way_dirty    (way_dirty),
        .way_line     (way_line),
        .req_tag      (req_tag),
        .req_word     (req_word),
        .req_index    (lookup_index),
        .victim_way   (victim_way),
        .hit          (hit),
        .hit_way      (hit_way),
        .hit_word     (hit_word),
        .victim_dirty (victim_dirty),
        .victim_line  (victim_line),
        .victim_addr  (victim_addr)
    );

    // refill always fetches the whole line
    axi_burst_master u_axi (
        .clk          (clk),
        .arst_n       (arst_n),
        .fill_start   (fill_start),
        .fill_dirty   (fill_dirty),
        .fill_addr    ({req_tag, lookup_index, {OFFSET_W{1'b0}}}),
        .victim_addr  (victim_addr),
        .victim_line  (victim_line),
        .fill_beat    (fill_beat),
        .fill_data    (fill_data),
        .fill_done    (fill_done),
        .ar_valid     (ar_valid),
        .ar           (ar),
        .ar_ready     (ar_ready),
        .r_valid      (r_valid),
        .r            (r),
        .r_ready      (r_ready),
        .aw_valid     (aw_valid),
        .aw           (aw),
        .aw_ready     (aw_ready),
        .w_valid      (w_valid),
        .w            (w),
        .w_ready      (w_ready),
        .b_valid      (b_valid)
    );

endmodule

`default_nettype wire

// ==== cache/cache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl #(
    parameter  int index_w = cache_pkg::DEF_INDEX_W,
    localparam int tag_w   = cache_pkg::ADDR_W - index_w - cache_pkg::OFFSET_W
) (
    input  wire                              clk,
    input  wire                              arst_n,
    input  wire                              req_valid,
    input  wire cache_pkg::cache_req_t       req,
    output logic                             rsp_valid,
    output cache_pkg::cache_rsp_t            rsp,
    output logic [index_w-1:0]               lookup_index,
    output cache_pkg::way_wr_t               way_wr,
    output logic [cache_pkg::WAYS-1:0]       way_we,
    input  wire                              hit,
    input  wire                              hit_way,
    input  wire [cache_pkg::WORD_W-1:0]      hit_word,
    input  wire                              victim_dirty,
    output logic [tag_w-1:0]                 req_tag,
    output logic [cache_pkg::WORD_SEL_W-1:0] req_word,
    output logic                             victim_way,
    output logic                             fill_start,
    output logic                             fill_dirty,
    input  wire                              fill_beat,
    input  wire [cache_pkg::WORD_W-1:0]      fill_data,
    input  wire                              fill_done
);
    import cache_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_compare,
        st_fill,
        st_respond
    } state_t;

    state_t                state;
    cache_req_t            req_q;
    logic [index_w-1:0]    req_index;
    logic [2**index_w-1:0] lru;
    logic [WORD_SEL_W-1:0] fill_cnt;
    logic [WORD_W-1:0]     fill_word;

    assign req_tag   = req_q.addr[ADDR_W-1 -: tag_w];
    assign req_index = req_q.addr[OFFSET_W +: index_w];
    assign req_word  = req_q.addr[OFFSET_W-1 -: WORD_SEL_W];

    // look up straight from the port in idle so the hit is known next cycle
    assign lookup_index = (state == st_idle) ? req.addr[OFFSET_W +: index_w] : req_index;

    // lru bit points at the way to replace
    assign victim_way = lru[req_index];

    assign fill_start = (state == st_compare) && !hit;
    assign fill_dirty = victim_dirty;

    assign rsp_valid = ((state == st_compare) && hit) || (state == st_respond);
    assign rsp.rdata = (state == st_respond) ? fill_word : hit_word;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= st_idle;
            lru      <= '0;
            fill_cnt <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (req_valid) begin
                        state <= st_compare;
                    end
                end
                st_compare: begin
                    if (hit) begin
                        lru[req_index] <= ~hit_way;
                        state          <= st_idle;
                    end else begin
                        fill_cnt <= '0;
                        state    <= st_fill;
                    end
                end
                st_fill: begin
                    if (fill_beat) begin
                        fill_cnt <= fill_cnt + 1'b1;
                    end
                    if (fill_done) begin
                        state <= st_respond;
                    end
                end
                st_respond: begin
                    lru[req_index] <= ~lru[req_index];
                    state          <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == st_idle) && req_valid) begin
            req_q <= req;
        end
        // grab the requested word as it streams past
        if ((state == st_fill) && fill_beat && (fill_cnt == req_word)) begin
            fill_word <= fill_data;
        end
    end

    always_comb begin
        way_we       = '0;
        way_wr       = '0;
        way_wr.index = DEF_INDEX_W'(req_index);
        way_wr.tag   = DEF_TAG_W'(req_tag);
        way_wr.word  = req_word;
        way_wr.be    = req_q.strb;
        way_wr.data  = req_q.wdata;
        case (state)
            st_compare: begin
                if (hit && req_q.write) begin
                    way_we[hit_way] = 1'b1;
                    way_wr.dirty    = 1'b1;
                end
            end
            st_fill: begin
                if (fill_beat) begin
                    way_we[victim_way] = 1'b1;
                    way_wr.word        = fill_cnt;
                    way_wr.be          = '1;
                    way_wr.data        = fill_data;
                end
            end
            st_respond: begin
                // install the tag, then merge a pending write
                way_we[victim_way] = 1'b1;
                way_wr.tag_we      = 1'b1;
                way_wr.set_valid   = 1'b1;
                way_wr.dirty       = req_q.write;
                if (!req_q.write) begin
                    way_wr.be = '0;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== cache/way_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

module way_merge #(
    parameter  int index_w = cache_pkg::DEF_INDEX_W,
    localparam int tag_w   = cache_pkg::ADDR_W - index_w - cache_pkg::OFFSET_W
) (
    input  wire [cache_pkg::WAYS-1:0][tag_w-1:0]  way_tag,
    input  wire [cache_pkg::WAYS-1:0]             way_valid,
    input  wire [cache_pkg::WAYS-1:0]             way_dirty,
    input  wire cache_pkg::line_t [cache_pkg::WAYS-1:0] way_line,
    input  wire [tag_w-1:0]                       req_tag,
    input  wire [cache_pkg::WORD_SEL_W-1:0]       req_word,
    input  wire [index_w-1:0]                     req_index,
    input  wire                                   victim_way,
    output logic                                  hit,
    output logic                                  hit_way,
    output logic [cache_pkg::WORD_W-1:0]          hit_word,
    output logic                                  victim_dirty,
    output cache_pkg::line_t                      victim_line,
    output logic [cache_pkg::ADDR_W-1:0]          victim_addr
);
    import cache_pkg::*;

    logic [WAYS-1:0] way_hit;

    always_comb begin
        hit     = 1'b0;
        hit_way = 1'b0;
        for (int i = 0; i < WAYS; i++) begin
            way_hit[i] = way_valid[i] && (way_tag[i] == req_tag);
            if (way_hit[i]) begin
                hit     = 1'b1;
                hit_way = 1'(i);
            end
        end
    end

    assign hit_word = way_line[hit_way][req_word];

    // victim sits in the same set as the request
    assign victim_line  = way_line[victim_way];
    assign victim_addr  = {way_tag[victim_way], req_index, {OFFSET_W{1'b0}}};
    assign victim_dirty = way_valid[victim_way] && way_dirty[victim_way];

endmodule

`default_nettype wire

// ==== cache/cache_way.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_way #(
    parameter  int index_w = cache_pkg::DEF_INDEX_W,
    localparam int tag_w   = cache_pkg::ADDR_W - index_w - cache_pkg::OFFSET_W
) (
    input  wire                      clk,
    input  wire                      arst_n,
    input  wire [index_w-1:0]        lookup_index,
    input  wire cache_pkg::way_wr_t  wr,
    input  wire                      we,
    output logic [tag_w-1:0]         tag,
    output logic                     valid,
    output logic                     dirty,
    output cache_pkg::line_t         line
);
    import cache_pkg::*;

    localparam int num_sets = 2**index_w;

    logic [tag_w-1:0]       tag_mem [num_sets];
    logic [num_sets-1:0]    valid_q;
    logic [num_sets-1:0]    dirty_q;
    logic [STRB_W-1:0][7:0] data_mem [WORDS_PER_LINE][num_sets];
    logic [index_w-1:0]     wr_index;

    assign wr_index = wr.index[index_w-1:0];

    // state bits, cleared on reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
            valid   <= 1'b0;
            dirty   <= 1'b0;
        end else begin
            if (we) begin
                dirty_q[wr_index] <= wr.dirty;
                if (wr.set_valid) begin
                    valid_q[wr_index] <= 1'b1;
                end
            end
            valid <= valid_q[lookup_index];
            dirty <= dirty_q[lookup_index];
        end
    end

    // tag and data arrays, read before write
    always_ff @(posedge clk) begin
        if (we && wr.tag_we) begin
            tag_mem[wr_index] <= wr.tag[tag_w-1:0];
        end
        if (we) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (wr.be[b]) begin
                    data_mem[wr.word][wr_index][b] <= wr.data[8*b +: 8];
                end
            end
        end
        tag <= tag_mem[lookup_index];
        for (int i = 0; i < WORDS_PER_LINE; i++) begin
            line[i] <= data_mem[i][lookup_index];
        end
    end

endmodule

`default_nettype wire

// ==== logic/axi_burst_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_burst_master (
    input  wire                              clk,
    input  wire                              arst_n,
    input  wire                              fill_start,
    input  wire                              fill_dirty,
    input  wire [cache_pkg::ADDR_W-1:0]      fill_addr,
    input  wire [cache_pkg::ADDR_W-1:0]      victim_addr,
    input  wire cache_pkg::line_t            victim_line,
    output logic                             fill_beat,
    output logic [cache_pkg::WORD_W-1:0]     fill_data,
    output logic                             fill_done,
    output logic                             ar_valid,
    output cache_pkg::axi_addr_t             ar,
    input  wire                              ar_ready,
    input  wire                              r_valid,
    input  wire cache_pkg::axi_data_t        r,
    output logic                             r_ready,
    output logic                             aw_valid,
    output cache_pkg::axi_addr_t             aw,
    input  wire                              aw_ready,
    output logic                             w_valid,
    output cache_pkg::axi_data_t             w,
    input  wire                              w_ready,
    input  wire                              b_valid
);
    import cache_pkg::*;

    logic                  rd_busy;
    logic                  wr_busy;
    logic                  w_active;
    logic                  fill_busy;
    logic [WORD_SEL_W-1:0] w_cnt;
    line_t                 wline;

    assign r_ready   = rd_busy;
    assign fill_beat = r_valid && rd_busy;
    assign fill_data = r.data;

    assign w_valid = w_active;
    assign w       = '{data: wline[w_cnt], last: (w_cnt == WORD_SEL_W'(BURST_LEN))};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ar_valid  <= 1'b0;
            aw_valid  <= 1'b0;
            rd_busy   <= 1'b0;
            wr_busy   <= 1'b0;
            w_active  <= 1'b0;
            fill_busy <= 1'b0;
            fill_done <= 1'b0;
            w_cnt     <= '0;
        end else begin
            fill_done <= 1'b0;
            if (fill_start) begin
                ar_valid  <= 1'b1;
                rd_busy   <= 1'b1;
                fill_busy <= 1'b1;
                aw_valid  <= fill_dirty;
                wr_busy   <= fill_dirty;
                w_cnt     <= '0;
            end
            if (ar_valid && ar_ready) begin
                ar_valid <= 1'b0;
            end
            // data follows once the write address is taken
            if (aw_valid && aw_ready) begin
                aw_valid <= 1'b0;
                w_active <= 1'b1;
            end
            if (w_valid && w_ready) begin
                w_cnt <= w_cnt + 1'b1;
                if (w.last) begin
                    w_active <= 1'b0;
                end
            end
            if (wr_busy && !aw_valid && !w_active && b_valid) begin
                wr_busy <= 1'b0;
            end
            if (fill_beat && r.last) begin
                rd_busy <= 1'b0;
            end
            // done only when refill and write-back have both finished
            if (fill_busy && !rd_busy && !wr_busy) begin
                fill_done <= 1'b1;
                fill_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_start) begin
            ar.addr <= fill_addr;
            aw.addr <= victim_addr;
            wline   <= victim_line;
        end
    end

endmodule

`default_nettype wire

// ==== common/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;
    localparam int STRB_W = 4;

    // line geometry
    localparam int WORDS_PER_LINE = 8;
    localparam int OFFSET_W       = 5;
    localparam int WORD_SEL_W     = 3;

    localparam int DEF_INDEX_W = 7;
    localparam int DEF_TAG_W   = ADDR_W - DEF_INDEX_W - OFFSET_W;
    localparam int WAYS        = 2;

    // axi length field for one full line
    localparam int BURST_LEN = WORDS_PER_LINE - 1;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              write;
        logic [STRB_W-1:0] strb;
        logic [WORD_W-1:0] wdata;
    } cache_req_t;

    typedef struct packed {
        logic [WORD_W-1:0] rdata;
    } cache_rsp_t;

    typedef logic [WORDS_PER_LINE-1:0][WORD_W-1:0] line_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } axi_addr_t;

    typedef struct packed {
        logic [WORD_W-1:0] data;
        logic              last;
    } axi_data_t;

    // dirty is written along with every word write
    typedef struct packed {
        logic [DEF_INDEX_W-1:0] index;
        logic [WORD_SEL_W-1:0]  word;
        logic [STRB_W-1:0]      be;
        logic [WORD_W-1:0]      data;
        logic                   tag_we;
        logic [DEF_TAG_W-1:0]   tag;
        logic                   set_valid;
        logic                   dirty;
    } way_wr_t;

endpackage

`default_nettype wire
